// File: verilog/mgmt_io_pkg.sv
// Shared types and constants for the management I/O block
package mgmt_io_pkg;

	// Drive mode codes, matching the dm[2:0] pins of the pad cell
	localparam logic [2:0] DM_OFF        = 3'b000;	// No drive, input buffer off
	localparam logic [2:0] DM_INPUT      = 3'b001;	// Input only
	localparam logic [2:0] DM_OPEN_DRAIN = 3'b011;	// Pulls low, never drives high
	localparam logic [2:0] DM_PUSH_PULL  = 3'b110;	// Strong drive both ways

	// SPI flash read
	localparam logic [7:0] FLASH_CMD_READ = 8'h03;	// Plain read, no dummy cycles
	localparam int FLASH_ADDR_W = 24;
	localparam int FLASH_DATA_W = 8;

	// Command plus address, sent as one word
	localparam int FLASH_SR_W = $bits(FLASH_CMD_READ) + FLASH_ADDR_W;

	// Counter must hold both the bit index and the read-phase cycle count
	localparam int FLASH_CNT_W = $clog2(FLASH_SR_W);

	// Read phase length in clock cycles, two per SPI bit
	localparam int FLASH_IN_CYC = 2 * FLASH_DATA_W;

	// Core side controls of one pad
	typedef struct packed {
		logic       dout;	// Value to drive
		logic       oeb;	// Output enable, active low
		logic       ieb;	// Input enable, active low
		logic [2:0] dm;	// Drive mode
	} pad_ctrl_t;

	// GPIO setting as written by software
	typedef struct packed {
		logic [2:0] dm;
		logic       dout;
	} gpio_cfg_t;

endpackage

// File: verilog/gpio_ctrl.sv
`timescale 1ns/1ps

// Management GPIO pin
// Holds the mode and output value, derives the enables from the mode
module gpio_ctrl import mgmt_io_pkg::*; (
	input  logic      clock,
	input  logic      rst_n,
	input  logic      gpio_wr,	// One-cycle load strobe
	input  gpio_cfg_t gpio_cfg,
	input  logic      gpio_in,	// Raw input from the pad, asynchronous to clock
	output pad_ctrl_t gpio_pad,
	output logic      gpio_in_sync
);

	logic [2:0] dm_q;	// Current drive mode
	logic       dout_q;	// Current output value
	logic       sync1_q;	// First synchronizer stage
	logic       sync2_q;	// Second stage, safe to use in the core
	logic       drive_mode;
	logic       input_mode;

	// Mode and output register
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			dm_q   <= DM_OFF;	// Pin floats out of reset
			dout_q <= 1'b0;
		end else if (gpio_wr) begin
			dm_q   <= gpio_cfg.dm;
			dout_q <= gpio_cfg.dout;
		end
	end

	// Output buffer is used by push-pull and open-drain
	assign drive_mode = (dm_q == DM_PUSH_PULL) || (dm_q == DM_OPEN_DRAIN);

	// Any mode except off keeps the input buffer on
	assign input_mode = (dm_q != DM_OFF);

	always_comb begin
		gpio_pad.dout = dout_q;
		gpio_pad.oeb  = ~drive_mode;
		gpio_pad.ieb  = ~input_mode;
		gpio_pad.dm   = dm_q;
	end

	// Two flop synchronizer on the pad input
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			sync1_q <= 1'b0;
			sync2_q <= 1'b0;
		end else begin
			sync1_q <= gpio_in;	// May go metastable
			sync2_q <= sync1_q;
		end
	end

	assign gpio_in_sync = sync2_q;

endmodule

// File: verilog/flash_spi_ctrl.sv
`timescale 1ns/1ps

// Single-lane SPI flash read engine
// Sends 03h and a 24-bit address on io0, then reads one byte on io1
// SPI clock runs at half the system clock, mode 0
module flash_spi_ctrl import mgmt_io_pkg::*; (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    rd_req,	// One-cycle strobe, dropped while busy
	input  logic [FLASH_ADDR_W-1:0] rd_addr,
	input  logic                    io1_in,	// Gated input from the io1 pad
	output logic                    busy,
	output logic                    rd_valid,	// One-cycle pulse with rd_data
	output logic [FLASH_DATA_W-1:0] rd_data,
	output pad_ctrl_t               csb_pad,
	output pad_ctrl_t               clk_pad,
	output pad_ctrl_t               io0_pad,
	output pad_ctrl_t               io1_pad
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SHIFT_OUT,	// Command and address on io0
		ST_SHIFT_IN	// Data byte from io1
	} state_t;

	state_t                  state_q;
	logic                    csb_q;	// Chip select, registered for a clean pin
	logic                    clk_q;	// SPI clock level
	logic [FLASH_CNT_W-1:0]  cnt_q;	// Bits sent, or cycles spent in the read phase
	logic [FLASH_SR_W-1:0]   sr_q;	// Outgoing word, MSB on the pin
	logic [FLASH_DATA_W-1:0] rx_q;	// Incoming byte
	logic                    accept;	// Request taken this cycle
	logic                    last_out;	// Final bit of the outgoing word
	logic                    in_done;	// Read phase finished

	assign accept   = (state_q == ST_IDLE) && rd_req;
	assign last_out = (cnt_q == FLASH_CNT_W'(FLASH_SR_W - 1));
	assign in_done  = (cnt_q == FLASH_CNT_W'(FLASH_IN_CYC));

	// Control FSM
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state_q  <= ST_IDLE;
			csb_q    <= 1'b1;
			clk_q    <= 1'b0;
			cnt_q    <= '0;
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (rd_req) begin
						state_q <= ST_SHIFT_OUT;
						csb_q   <= 1'b0;	// Select drops with busy
						cnt_q   <= '0;
					end
				end
				ST_SHIFT_OUT: begin
					clk_q <= ~clk_q;
					// A bit ends when clk falls
					if (clk_q) begin
						cnt_q <= cnt_q + 1'b1;
						if (last_out) begin
							state_q <= ST_SHIFT_IN;
							cnt_q   <= '0;
						end
					end
				end
				ST_SHIFT_IN: begin
					if (in_done) begin
						// Clock is already low here
						state_q  <= ST_IDLE;
						csb_q    <= 1'b1;
						rd_valid <= 1'b1;
					end else begin
						clk_q <= ~clk_q;
						cnt_q <= cnt_q + 1'b1;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// Shift registers
	always_ff @(posedge clock) begin
		if (accept)
			sr_q <= {FLASH_CMD_READ, rd_addr};	// Command goes out first
		else if ((state_q == ST_SHIFT_OUT) && clk_q)
			sr_q <= {sr_q[FLASH_SR_W-2:0], 1'b0};

		// Sample io1 as clk rises, the device changed it on the fall before
		if ((state_q == ST_SHIFT_IN) && !clk_q && !in_done)
			rx_q <= {rx_q[FLASH_DATA_W-2:0], io1_in};
	end

	assign busy    = (state_q != ST_IDLE);
	assign rd_data = rx_q;	// Holds until the next read starts

	// Pad controls
	assign csb_pad = '{dout: csb_q, oeb: 1'b0, ieb: 1'b1, dm: DM_PUSH_PULL};
	assign clk_pad = '{dout: clk_q, oeb: 1'b0, ieb: 1'b1, dm: DM_PUSH_PULL};

	// io0 only drives while the word is going out
	assign io0_pad = '{
		dout: sr_q[FLASH_SR_W-1],
		oeb:  (state_q != ST_SHIFT_OUT),
		ieb:  1'b1,
		dm:   DM_PUSH_PULL
	};

	// io1 is a plain input in single-lane mode
	assign io1_pad = '{dout: 1'b0, oeb: 1'b1, ieb: 1'b0, dm: DM_INPUT};

endmodule

// File: verilog/pad_ring.sv
`timescale 1ns/1ps

// Behavioral padframe for the management pins
// Each pin gets its own cell: drive enable, pin driver and input gate
module pad_ring import mgmt_io_pkg::*; (
	input  pad_ctrl_t gpio_pad,
	input  pad_ctrl_t csb_pad,
	input  pad_ctrl_t clk_pad,
	input  pad_ctrl_t io0_pad,
	input  pad_ctrl_t io1_pad,
	output logic      gpio_in,	// Core side input of the gpio pin
	output logic      io1_in,	// Core side input of flash_io1
	output logic      flash_csb,
	output logic      flash_clk,
	inout  wire       gpio,
	inout  wire       flash_io0,
	inout  wire       flash_io1
);

	// Pad drives when enabled in push-pull mode
	// Open-drain pulls low whatever oeb says
	function automatic logic pad_oe(input pad_ctrl_t p);
		logic pp_drive;
		logic od_drive;
		pp_drive = !p.oeb && (p.dm == DM_PUSH_PULL);
		od_drive = (p.dm == DM_OPEN_DRAIN) && !p.dout;
		return pp_drive || od_drive;
	endfunction

	// Input buffer passes the pin only when enabled and not off
	function automatic logic pad_in(input pad_ctrl_t p, input logic pin);
		return (!p.ieb && (p.dm != DM_OFF)) ? pin : 1'b0;
	endfunction

	logic gpio_oe;
	logic csb_oe;
	logic clk_oe;
	logic io0_oe;
	logic io1_oe;

	// Management GPIO, bidirectional
	assign gpio_oe = pad_oe(gpio_pad);
	assign gpio    = gpio_oe ? gpio_pad.dout : 1'bz;
	assign gpio_in = pad_in(gpio_pad, gpio);

	// Flash chip select, output only
	assign csb_oe    = pad_oe(csb_pad);
	assign flash_csb = csb_oe ? csb_pad.dout : 1'bz;

	// Flash clock, output only
	assign clk_oe    = pad_oe(clk_pad);
	assign flash_clk = clk_oe ? clk_pad.dout : 1'bz;

	// Flash io0
	// Input side has no core consumer in single-lane mode
	assign io0_oe    = pad_oe(io0_pad);
	assign flash_io0 = io0_oe ? io0_pad.dout : 1'bz;

	// Flash io1, read data from the device
	assign io1_oe    = pad_oe(io1_pad);
	assign flash_io1 = io1_oe ? io1_pad.dout : 1'bz;
	assign io1_in    = pad_in(io1_pad, flash_io1);

endmodule

// File: verilog/mgmt_io_top.sv
`timescale 1ns/1ps

// Management I/O subsystem
// GPIO and flash controllers side by side, feeding one pad ring
module mgmt_io_top import mgmt_io_pkg::*; (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    gpio_wr,
	input  gpio_cfg_t               gpio_cfg,
	input  logic                    rd_req,
	input  logic [FLASH_ADDR_W-1:0] rd_addr,
	output logic                    gpio_in_sync,
	output logic                    busy,
	output logic                    rd_valid,
	output logic [FLASH_DATA_W-1:0] rd_data,
	output logic                    flash_csb,
	output logic                    flash_clk,
	inout  wire                     gpio,
	inout  wire                     flash_io0,
	inout  wire                     flash_io1
);

	pad_ctrl_t gpio_pad;
	pad_ctrl_t csb_pad;
	pad_ctrl_t clk_pad;
	pad_ctrl_t io0_pad;
	pad_ctrl_t io1_pad;
	logic      gpio_in;	// Raw, not yet synchronized
	logic      io1_in;

	gpio_ctrl u_gpio_ctrl (
		.clock        (clock),
		.rst_n        (rst_n),
		.gpio_wr      (gpio_wr),
		.gpio_cfg     (gpio_cfg),
		.gpio_in      (gpio_in),
		.gpio_pad     (gpio_pad),
		.gpio_in_sync (gpio_in_sync)
	);

	flash_spi_ctrl u_flash_spi_ctrl (
		.clock    (clock),
		.rst_n    (rst_n),
		.rd_req   (rd_req),
		.rd_addr  (rd_addr),
		.io1_in   (io1_in),
		.busy     (busy),
		.rd_valid (rd_valid),
		.rd_data  (rd_data),
		.csb_pad  (csb_pad),
		.clk_pad  (clk_pad),
		.io0_pad  (io0_pad),
		.io1_pad  (io1_pad)
	);

	pad_ring u_pad_ring (
		.gpio_pad  (gpio_pad),
		.csb_pad   (csb_pad),
		.clk_pad   (clk_pad),
		.io0_pad   (io0_pad),
		.io1_pad   (io1_pad),
		.gpio_in   (gpio_in),
		.io1_in    (io1_in),
		.flash_csb (flash_csb),
		.flash_clk (flash_clk),
		.gpio      (gpio),
		.flash_io0 (flash_io0),
		.flash_io1 (flash_io1)
	);

endmodule

// File: dv/mgmt_io_props.sv
`timescale 1ns/1ps

// Protocol assertions on the flash read engine
// Bound into flash_spi_ctrl, so it sees the registered pin levels
module mgmt_io_props (
	input logic clock,
	input logic rst_n,
	input logic busy,
	input logic csb_q,	// Chip select level
	input logic clk_q,	// SPI clock level
	input logic rd_valid
);

	// Chip select held low for the whole transfer
	a_csb_low_while_busy: assert property (@(posedge clock) disable iff (!rst_n)
		busy |-> !csb_q) else $error("flash_csb high while busy");

	// Clock idles low and stays put while deselected
	a_clk_quiet: assert property (@(posedge clock) disable iff (!rst_n)
		(csb_q && $past(csb_q)) |-> (!clk_q && (clk_q == $past(clk_q))))
		else $error("flash_clk moved while flash_csb high");

	// Single-cycle valid pulse
	a_valid_pulse: assert property (@(posedge clock) disable iff (!rst_n)
		rd_valid |=> !rd_valid) else $error("rd_valid longer than one cycle");

	// Reset puts the pins in their idle levels
	a_reset_state: assert property (@(posedge clock)
		!rst_n |=> (csb_q && !clk_q && !rd_valid)) else $error("bad reset state");

endmodule

bind flash_spi_ctrl mgmt_io_props u_props (
	.clock    (clock),
	.rst_n    (rst_n),
	.busy     (busy),
	.csb_q    (csb_q),
	.clk_q    (clk_q),
	.rd_valid (rd_valid)
);

// File: dv/mgmt_io_checker.sv
`timescale 1ns/1ps

// Watches the DUT ports and compares against the expected behavior
module mgmt_io_checker import mgmt_io_pkg::*; (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    rd_req,
	input  logic [FLASH_ADDR_W-1:0] rd_addr,
	input  logic                    busy,
	input  logic                    rd_valid,
	input  logic [FLASH_DATA_W-1:0] rd_data,
	input  logic                    flash_csb,
	input  logic                    flash_clk,
	input  logic                    gpio,	// Pulled up in the testbench
	input  logic                    gpio_in_sync,
	input  logic                    chk_pin,	// Compare the gpio pin this cycle
	input  logic                    chk_sync,	// Compare gpio_in_sync this cycle
	input  logic                    chk_val,
	input  logic                    end_of_test,
	output int                      error_count
);

	localparam int READ_LAT = 82;	// Accepted strobe to rd_valid

	int                      cyc = 0;
	int                      reads_done = 0;
	logic                    rst_seen = 1'b0;
	logic                    summary_done = 1'b0;
	logic [FLASH_ADDR_W-1:0] addr_q[$];	// Accepted addresses in order
	int                      start_q[$];	// Cycle of each accepted strobe

	initial error_count = 0;

	// Flash contents: XOR of the address bytes, then 5Ah
	function automatic logic [7:0] mem_byte(input logic [23:0] a);
		return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5a;
	endfunction

	task automatic check_val(input string name, input int got, input int exp);
		if (got !== exp) begin
			error_count++;
			$display("CHECK FAILED t=%0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	always @(posedge clock) begin : compare
		logic [FLASH_ADDR_W-1:0] a;
		int                      t0;
		logic                    exp_busy;
		// A read is in flight until its latency has run out
		exp_busy = 1'b0;
		if (start_q.size() != 0)
			exp_busy = (cyc - start_q[0]) < READ_LAT;
		// First cycle out of reset
		if (rst_n && !rst_seen) begin
			rst_seen = 1'b1;
			check_val("flash_csb", int'(flash_csb), 1);
			check_val("flash_clk", int'(flash_clk), 0);
			check_val("busy", int'(busy), 0);
			check_val("rd_valid", int'(rd_valid), 0);
			check_val("gpio", int'(gpio), 1);	// Reads the pullup when undriven
		end
		// Select low for the whole transfer, clock parked low otherwise
		if (rst_n) begin
			check_val("busy", int'(busy), int'(exp_busy));
			check_val("flash_csb", int'(flash_csb), int'(!exp_busy));
			if (!exp_busy)
				check_val("flash_clk", int'(flash_clk), 0);
		end
		if (rst_n && chk_pin)
			check_val("gpio", int'(gpio), int'(chk_val));
		if (rst_n && chk_sync)
			check_val("gpio_in_sync", int'(gpio_in_sync), int'(chk_val));
		// Strobes made while a read is in flight are dropped
		if (rst_n && rd_req && !exp_busy) begin
			addr_q.push_back(rd_addr);
			start_q.push_back(cyc);
		end
		if (rst_n && rd_valid) begin
			if (addr_q.size() == 0) begin
				error_count++;
				$display("rd_valid at t=%0t with no read outstanding", $time);
			end else begin
				a  = addr_q.pop_front();
				t0 = start_q.pop_front();
				reads_done++;
				check_val("read latency", cyc - t0, READ_LAT);
				check_val("rd_data", int'(rd_data), int'(mem_byte(a)));
			end
		end
		if (end_of_test && !summary_done) begin
			summary_done = 1'b1;
			if (addr_q.size() != 0) begin
				error_count++;
				$display("%0d accepted reads never returned rd_valid", addr_q.size());
			end
			$display("Checker summary: %0d reads completed, %0d errors", reads_done,
				error_count);
		end
		cyc++;
	end

endmodule

// File: dv/mgmt_io_tb.sv
`timescale 1ns/1ps

// Testbench top for the management I/O subsystem
module mgmt_io_tb import mgmt_io_pkg::*; ();

	localparam int NUM_READS = 12;
	localparam int WATCHDOG_CYC = NUM_READS * 100 + 2000;

	logic                    clock;
	logic                    rst_n;
	logic                    gpio_wr;
	gpio_cfg_t               gpio_cfg;
	logic                    rd_req;
	logic [FLASH_ADDR_W-1:0] rd_addr;
	logic                    gpio_in_sync;
	logic                    busy;
	logic                    rd_valid;
	logic [FLASH_DATA_W-1:0] rd_data;
	logic                    flash_csb;
	logic                    flash_clk;
	wire                     gpio;
	wire                     flash_io0;
	wire                     flash_io1;
	logic                    pin_en;	// Testbench drive on the gpio pin
	logic                    pin_val;
	logic                    chk_pin;
	logic                    chk_sync;
	logic                    chk_val;
	logic                    end_of_test;
	logic [31:0]             lfsr_q;
	int                      error_count;

	// Flash device model state
	logic        io1_en = 1'b0;
	logic        io1_val = 1'b0;
	logic [31:0] dev_word = '0;	// Command and address as received
	int          dev_bits = 0;
	int          dev_out = 0;
	logic [7:0]  dev_byte = '0;

	assign gpio = pin_en ? pin_val : 1'bz;
	pullup pu_gpio (gpio);	// Makes a floating pin visible as 1
	assign flash_io1 = io1_en ? io1_val : 1'bz;

	always #5 clock = ~clock;

	mgmt_io_top DUT (
		.clock        (clock),
		.rst_n        (rst_n),
		.gpio_wr      (gpio_wr),
		.gpio_cfg     (gpio_cfg),
		.rd_req       (rd_req),
		.rd_addr      (rd_addr),
		.gpio_in_sync (gpio_in_sync),
		.busy         (busy),
		.rd_valid     (rd_valid),
		.rd_data      (rd_data),
		.flash_csb    (flash_csb),
		.flash_clk    (flash_clk),
		.gpio         (gpio),
		.flash_io0    (flash_io0),
		.flash_io1    (flash_io1)
	);

	mgmt_io_checker u_checker (
		.clock        (clock),
		.rst_n        (rst_n),
		.rd_req       (rd_req),
		.rd_addr      (rd_addr),
		.busy         (busy),
		.rd_valid     (rd_valid),
		.rd_data      (rd_data),
		.flash_csb    (flash_csb),
		.flash_clk    (flash_clk),
		.gpio         (gpio),
		.gpio_in_sync (gpio_in_sync),
		.chk_pin      (chk_pin),
		.chk_sync     (chk_sync),
		.chk_val      (chk_val),
		.end_of_test  (end_of_test),
		.error_count  (error_count)
	);

	function automatic logic [7:0] mem_byte(input logic [23:0] a);
		return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5a;
	endfunction

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v      = {v[30:0], lfsr_q[0]};	// One step per bit
		end
	endtask

	// Device side of the SPI bus, mode 0
	always @(posedge flash_clk, negedge flash_clk, posedge flash_csb) begin
		if (flash_csb === 1'b1) begin
			io1_en   = 1'b0;	// Release on deselect
			dev_bits = 0;
			dev_out  = 0;
		end else if (flash_clk) begin
			if (dev_bits < 32) begin
				dev_word = {dev_word[30:0], flash_io0};
				dev_bits++;
			end
		end else if (dev_bits == 32 && dev_out < 8) begin
			if (dev_out == 0)	// Wrong command gives wrong data
				dev_byte = (dev_word[31:24] == FLASH_CMD_READ) ? mem_byte(dev_word[23:0])
					: ~mem_byte(dev_word[23:0]);
			io1_val = dev_byte[7 - dev_out];
			io1_en  = 1'b1;
			dev_out++;
		end
	end

	task automatic write_gpio(input logic [2:0] dm, input logic v);
		gpio_wr  <= 1'b1;
		gpio_cfg <= '{dm: dm, dout: v};
		@(posedge clock);
		gpio_wr  <= 1'b0;
	endtask

	task automatic expect_values(input logic pin, input logic sync, input logic v);
		chk_pin  <= pin;
		chk_sync <= sync;
		chk_val  <= v;
		@(posedge clock);
		chk_pin  <= 1'b0;
		chk_sync <= 1'b0;
	endtask

	task automatic test_push_pull();
		logic [31:0] r;
		for (int i = 0; i < 4; i++) begin
			take_bits(1, r);
			write_gpio(DM_PUSH_PULL, r[0]);
			expect_values(1'b1, 1'b0, r[0]);	// Pin right after the load
			@(posedge clock);
			expect_values(1'b0, 1'b1, r[0]);	// Synchronized two cycles on
		end
	endtask

	task automatic drive_and_expect(input logic v, input logic exp);
		pin_en  <= 1'b1;
		pin_val <= v;
		repeat (2) @(posedge clock);
		expect_values(1'b0, 1'b1, exp);
	endtask

	task automatic test_input_modes();
		logic [31:0] r;
		write_gpio(DM_INPUT, 1'b0);
		for (int i = 0; i < 4; i++) begin
			take_bits(1, r);
			drive_and_expect(r[0], r[0]);
		end
		write_gpio(DM_OPEN_DRAIN, 1'b1);	// Released, pin follows the testbench
		for (int i = 0; i < 4; i++) begin
			take_bits(1, r);
			drive_and_expect(r[0], r[0]);
		end
		write_gpio(DM_OFF, 1'b0);
		drive_and_expect(1'b1, 1'b0);	// Input buffer off
		take_bits(1, r);
		drive_and_expect(r[0], 1'b0);
		pin_en <= 1'b0;
		@(posedge clock);
	endtask

	task automatic issue_read(input logic [FLASH_ADDR_W-1:0] a);
		rd_req  <= 1'b1;
		rd_addr <= a;
		@(posedge clock);
		rd_req  <= 1'b0;
	endtask

	task automatic test_flash_reads();
		logic [31:0] r;
		for (int i = 0; i < NUM_READS; i++) begin
			take_bits(FLASH_ADDR_W, r);
			issue_read(r[FLASH_ADDR_W-1:0]);
			if (i % 3 == 2) begin
				repeat (10) @(posedge clock);
				take_bits(FLASH_ADDR_W, r);
				issue_read(r[FLASH_ADDR_W-1:0]);	// Busy, so dropped
			end
			do
				@(posedge clock);
			while (!rd_valid);
		end
	endtask

	initial begin
		clock       = 1'b0;
		rst_n       = 1'b0;
		gpio_wr     = 1'b0;
		gpio_cfg    = '0;
		rd_req      = 1'b0;
		rd_addr     = '0;
		pin_en      = 1'b0;
		pin_val     = 1'b0;
		chk_pin     = 1'b0;
		chk_sync    = 1'b0;
		chk_val     = 1'b0;
		end_of_test = 1'b0;
		lfsr_q      = 32'h4e6d;
		repeat (5) @(posedge clock);
		rst_n <= 1'b1;
		repeat (3) @(posedge clock);	// Reset state checked meanwhile
		test_push_pull();
		test_input_modes();
		test_flash_reads();
		repeat (100) @(posedge clock);	// Room for a stray rd_valid
		end_of_test <= 1'b1;
		repeat (2) @(posedge clock);
		if (error_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYC) @(posedge clock);
		$display("Timeout after %0d cycles, the DUT stopped responding", WATCHDOG_CYC);
		$display("test failed");
		$finish;
	end

endmodule

// File: mgmt_io_top.f
verilog/mgmt_io_pkg.sv
verilog/gpio_ctrl.sv
verilog/flash_spi_ctrl.sv
verilog/pad_ring.sv
verilog/mgmt_io_top.sv
dv/mgmt_io_props.sv
dv/mgmt_io_checker.sv
dv/mgmt_io_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the management I/O testbench with Verilator
# Exit status is 0 only when the run prints the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module mgmt_io_tb \
	-f mgmt_io_top.f \
	-o mgmt_io_sim \
	|| { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/mgmt_io_sim) ; echo "$sim_out"

echo "$sim_out" | grep -qx "test passed" \
	&& exit 0 \
	|| exit 1
